// File: all.f
+incdir+.
cpu_pkg.sv
reg_file.sv
alu_branch.sv
cpu_core.sv
bus_arbiter.sv
apb_ram.sv
soc_top.sv
tb_soc.sv

// File: alu_branch.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu_branch (
  input  logic [`CPU_XLEN-1:0] op_a_i,
  input  logic [`CPU_XLEN-1:0] op_b_i,
  input  cpu_pkg::alu_op_e     alu_op_i,
  input  cpu_pkg::cmp_op_e     cmp_op_i,
  input  logic [`CPU_XLEN-1:0] pc_i,
  input  logic [`CPU_XLEN-1:0] offset_i,
  input  logic                 target_base_sel_i,
  output logic [`CPU_XLEN-1:0] result_o,
  output logic                 taken_o,
  output logic [`CPU_XLEN-1:0] target_o
);
  import cpu_pkg::*;

  logic                 lt;
  logic [`CPU_XLEN-1:0] target_sum;

  // signed compare, shared by slt and blt
  assign lt = $signed(op_a_i) < $signed(op_b_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:   result_o = op_a_i + op_b_i;
      ALU_SUB:   result_o = op_a_i - op_b_i;
      ALU_AND:   result_o = op_a_i & op_b_i;
      ALU_OR:    result_o = op_a_i | op_b_i;
      ALU_XOR:   result_o = op_a_i ^ op_b_i;
      ALU_SLT:   result_o = `CPU_XLEN'(lt);
      ALU_PASSB: result_o = op_b_i;
      default:   result_o = '0;
    endcase
  end

  always_comb begin
    case (cmp_op_i)
      CMP_EQ:  taken_o = (op_a_i == op_b_i);
      CMP_NE:  taken_o = (op_a_i != op_b_i);
      CMP_LT:  taken_o = lt;
      default: taken_o = 1'b0;
    endcase
  end

  // jal and branches are pc relative, jalr is rs1 relative
  assign target_sum = (target_base_sel_i ? op_a_i : pc_i) + offset_i;

  // jalr drops bit 0 of the sum
  assign target_o = {target_sum[`CPU_XLEN-1:1], target_sum[0] & ~target_base_sel_i};

endmodule

// File: apb_ram.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module apb_ram (
  input  logic              ACLK,
  input  logic              ARESETn,
  input  cpu_pkg::apb_req_t apb_i,
  output cpu_pkg::apb_rsp_t apb_o
);
  import cpu_pkg::*;

  localparam int IDX_W = $clog2(`CPU_RAM_WORDS);

  logic [`CPU_XLEN-1:0] mem_q [`CPU_RAM_WORDS];
  logic [`CPU_XLEN-1:0] rdata_q;
  logic [IDX_W-1:0]     idx;
  logic                 access;
  logic                 waited_q;
  logic                 ready;

  // word index, upper address bits wrap
  assign idx    = apb_i.paddr[IDX_W+1:2];
  assign access = apb_i.psel && apb_i.penable;
  assign ready  = access && waited_q;

  // one wait state per access phase
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      waited_q <= 1'b0;
    end else begin
      waited_q <= access && !waited_q;
    end
  end

  // read during the wait cycle, write on pready
  always_ff @(posedge ACLK) begin
    if (access && !waited_q) begin
      rdata_q <= mem_q[idx];
    end
    if (ready && apb_i.pwrite) begin
      mem_q[idx] <= apb_i.pwdata;
    end
  end

  assign apb_o = '{pready: ready, prdata: rdata_q};

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              ACLK,
  input  logic              ARESETn,
  input  logic              host_valid_i,
  input  cpu_pkg::mem_req_t host_req_i,
  output logic              host_done_o,
  output cpu_pkg::mem_rsp_t host_rsp_o,
  input  logic              data_valid_i,
  input  cpu_pkg::mem_req_t data_req_i,
  output logic              data_done_o,
  output cpu_pkg::mem_rsp_t data_rsp_o,
  input  logic              fetch_valid_i,
  input  cpu_pkg::mem_req_t fetch_req_i,
  output logic              fetch_done_o,
  output cpu_pkg::mem_rsp_t fetch_rsp_o,
  output cpu_pkg::apb_req_t apb_o,
  input  cpu_pkg::apb_rsp_t apb_i
);
  import cpu_pkg::*;

  apb_phase_e phase_q;
  owner_e     owner_q;
  mem_req_t   sel_req;
  logic       xfer_end;

  assign xfer_end = (phase_q == PH_ACCESS) && apb_i.pready;

  // grant only from idle, host > data > fetch
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      phase_q <= PH_IDLE;
      owner_q <= OWN_HOST;
    end else begin
      case (phase_q)
        PH_IDLE: begin
          if (host_valid_i) begin
            owner_q <= OWN_HOST;
            phase_q <= PH_SETUP;
          end else if (data_valid_i) begin
            owner_q <= OWN_DATA;
            phase_q <= PH_SETUP;
          end else if (fetch_valid_i) begin
            owner_q <= OWN_FETCH;
            phase_q <= PH_SETUP;
          end
        end
        PH_SETUP: phase_q <= PH_ACCESS;
        default: begin
          if (apb_i.pready) begin
            phase_q <= PH_IDLE;
          end
        end
      endcase
    end
  end

  // owner keeps its request steady for the whole transfer
  always_comb begin
    case (owner_q)
      OWN_DATA:  sel_req = data_req_i;
      OWN_FETCH: sel_req = fetch_req_i;
      default:   sel_req = host_req_i;
    endcase
  end

  assign apb_o = '{psel:    (phase_q != PH_IDLE),
                   penable: (phase_q == PH_ACCESS),
                   pwrite:  sel_req.write,
                   paddr:   sel_req.addr,
                   pwdata:  sel_req.wdata};

  assign host_done_o  = xfer_end && (owner_q == OWN_HOST);
  assign data_done_o  = xfer_end && (owner_q == OWN_DATA);
  assign fetch_done_o = xfer_end && (owner_q == OWN_FETCH);

  // read data fans out, done qualifies it
  assign host_rsp_o  = '{rdata: apb_i.prdata};
  assign data_rsp_o  = '{rdata: apb_i.prdata};
  assign fetch_rsp_o = '{rdata: apb_i.prdata};

endmodule

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_XLEN 32

// ram depth in words, power of two
`define CPU_RAM_WORDS 1024

// first fetch address after run
`define CPU_RESET_PC 0

`endif

// File: cpu_core.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core (
  input  logic              ACLK,
  input  logic              ARESETn,
  input  logic              run_i,
  output logic              busy_o,
  output logic              err_o,
  output logic              ifetch_valid_o,
  output cpu_pkg::mem_req_t ifetch_req_o,
  input  logic              ifetch_done_i,
  input  cpu_pkg::mem_rsp_t ifetch_rsp_i,
  output logic              data_valid_o,
  output cpu_pkg::mem_req_t data_req_o,
  input  logic              data_done_i,
  input  cpu_pkg::mem_rsp_t data_rsp_i
);
  import cpu_pkg::*;

  core_state_e          state_q;
  logic [`CPU_XLEN-1:0] pc_q;
  logic                 err_q;
  inst_u                ir_q;
  mem_req_t             data_req_q;

  // decoded controls
  alu_op_e              alu_op;
  alu_op_e              f3_op;
  logic                 f3_ok;
  cmp_op_e              cmp_op;
  wb_sel_e              wb_sel;
  logic [`CPU_XLEN-1:0] imm;
  logic                 use_imm;
  logic                 rf_wen;
  logic                 is_load;
  logic                 is_store;
  logic                 is_branch;
  logic                 is_jump;
  logic                 base_rs1;
  logic                 halt;
  logic                 illegal;

  logic [`CPU_XLEN-1:0] i_imm;
  logic [`CPU_XLEN-1:0] s_imm;
  logic [`CPU_XLEN-1:0] b_imm;
  logic [`CPU_XLEN-1:0] u_imm;
  logic [`CPU_XLEN-1:0] j_imm;

  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic [`CPU_XLEN-1:0] alu_result;
  logic                 taken;
  logic [`CPU_XLEN-1:0] target;
  logic [`CPU_XLEN-1:0] pc_plus4;
  logic                 rd_wen;
  logic [`CPU_XLEN-1:0] rd_wdata;

  // immediates through the format views
  assign i_imm = `CPU_XLEN'($signed(ir_q.i.imm));
  assign s_imm = `CPU_XLEN'($signed({ir_q.s.imm_hi, ir_q.s.imm_lo}));
  assign b_imm = `CPU_XLEN'($signed({ir_q.b.imm12, ir_q.b.imm11, ir_q.b.imm10_5,
                                     ir_q.b.imm4_1, 1'b0}));
  assign u_imm = `CPU_XLEN'($signed({ir_q.u.imm, 12'b0}));
  assign j_imm = `CPU_XLEN'($signed({ir_q.j.imm20, ir_q.j.imm19_12, ir_q.j.imm11,
                                     ir_q.j.imm10_1, 1'b0}));

  // funct3 map shared by op and op-imm
  always_comb begin
    f3_ok = 1'b1;
    case (ir_q.r.funct3)
      3'b000:  f3_op = ALU_ADD;
      3'b010:  f3_op = ALU_SLT;
      3'b100:  f3_op = ALU_XOR;
      3'b110:  f3_op = ALU_OR;
      3'b111:  f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    alu_op    = ALU_ADD;
    cmp_op    = CMP_EQ;
    wb_sel    = WB_ALU;
    imm       = i_imm;
    use_imm   = 1'b1;
    rf_wen    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    base_rs1  = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;
    case (ir_q.r.opcode)
      OPC_LUI: begin
        alu_op = ALU_PASSB;
        imm    = u_imm;
        rf_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op  = f3_op;
        illegal = !f3_ok;
        rf_wen  = 1'b1;
      end
      OPC_OP: begin
        use_imm = 1'b0;
        alu_op  = (ir_q.r.funct3 == 3'b000 && ir_q.r.funct7[5]) ? ALU_SUB : f3_op;
        illegal = !f3_ok;
        rf_wen  = 1'b1;
      end
      OPC_LOAD: begin
        is_load = 1'b1;
        rf_wen  = 1'b1;
        wb_sel  = WB_MEM;
        illegal = (ir_q.i.funct3 != 3'b010);
      end
      OPC_STORE: begin
        is_store = 1'b1;
        imm      = s_imm;
        illegal  = (ir_q.s.funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        is_branch = 1'b1;
        use_imm   = 1'b0;
        imm       = b_imm;
        case (ir_q.b.funct3)
          3'b000:  cmp_op = CMP_EQ;
          3'b001:  cmp_op = CMP_NE;
          3'b100:  cmp_op = CMP_LT;
          default: illegal = 1'b1;
        endcase
      end
      OPC_JAL: begin
        is_jump = 1'b1;
        imm     = j_imm;
        rf_wen  = 1'b1;
        wb_sel  = WB_PC4;
      end
      OPC_JALR: begin
        is_jump  = 1'b1;
        base_rs1 = 1'b1;
        rf_wen   = 1'b1;
        wb_sel   = WB_PC4;
      end
      OPC_SYSTEM: begin
        // only ebreak is supported
        halt    = (ir_q == 32'h0010_0073);
        illegal = !halt;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign pc_plus4 = pc_q + `CPU_XLEN'(4);

  // loads write back in the done cycle, everything else in exec
  assign rd_wen = !illegal && ((state_q == ST_EXEC && rf_wen && !is_load) ||
                               (state_q == ST_MEM && is_load && data_done_i));

  always_comb begin
    case (wb_sel)
      WB_PC4:  rd_wdata = pc_plus4;
      WB_MEM:  rd_wdata = data_rsp_i.rdata;
      default: rd_wdata = alu_result;
    endcase
  end

  reg_file u_reg_file (
    .ACLK,
    .rs1_idx_i  (ir_q.r.rs1),
    .rs2_idx_i  (ir_q.r.rs2),
    .rd_idx_i   (ir_q.r.rd),
    .rd_wen_i   (rd_wen),
    .rd_wdata_i (rd_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  alu_branch u_alu_branch (
    .op_a_i            (rs1_data),
    .op_b_i            (use_imm ? imm : rs2_data),
    .alu_op_i          (alu_op),
    .cmp_op_i          (cmp_op),
    .pc_i              (pc_q),
    .offset_i          (imm),
    .target_base_sel_i (base_rs1),
    .result_o          (alu_result),
    .taken_o           (taken),
    .target_o          (target)
  );

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q <= ST_IDLE;
      pc_q    <= `CPU_XLEN'(`CPU_RESET_PC);
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (run_i) begin
            pc_q    <= `CPU_XLEN'(`CPU_RESET_PC);
            err_q   <= 1'b0;
            state_q <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (ifetch_done_i) begin
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (halt || illegal) begin
            err_q   <= illegal;
            state_q <= ST_IDLE;
          end else begin
            pc_q    <= (is_jump || (is_branch && taken)) ? target : pc_plus4;
            state_q <= (is_load || is_store) ? ST_MEM : ST_FETCH;
          end
        end
        default: begin
          if (data_done_i) begin
            state_q <= ST_FETCH;
          end
        end
      endcase
    end
  end

  // instruction and data request payload
  always_ff @(posedge ACLK) begin
    if (state_q == ST_FETCH && ifetch_done_i) begin
      ir_q <= ifetch_rsp_i.rdata;
    end
    if (state_q == ST_EXEC) begin
      data_req_q <= '{addr: alu_result, wdata: rs2_data, write: is_store};
    end
  end

  assign ifetch_valid_o = (state_q == ST_FETCH);
  assign ifetch_req_o   = '{addr: pc_q, wdata: '0, write: 1'b0};
  assign data_valid_o   = (state_q == ST_MEM);
  assign data_req_o     = data_req_q;
  assign busy_o         = (state_q != ST_IDLE);
  assign err_o          = err_q;

endmodule

// File: cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  // rv32i opcodes in use
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASSB} alu_op_e;
  typedef enum logic [1:0] {CMP_EQ, CMP_NE, CMP_LT} cmp_op_e;
  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_e;
  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_EXEC, ST_MEM} core_state_e;
  typedef enum logic [1:0] {PH_IDLE, PH_SETUP, PH_ACCESS} apb_phase_e;
  typedef enum logic [1:0] {OWN_HOST, OWN_DATA, OWN_FETCH} owner_e;

  // word request, byte address
  typedef struct packed {
    logic [`CPU_XLEN-1:0] addr;
    logic [`CPU_XLEN-1:0] wdata;
    logic                 write;
  } mem_req_t;

  typedef struct packed {
    logic [`CPU_XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [`CPU_XLEN-1:0] paddr;
    logic [`CPU_XLEN-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                 pready;
    logic [`CPU_XLEN-1:0] prdata;
  } apb_rsp_t;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
  input  logic                 ACLK,
  input  logic [4:0]           rs1_idx_i,
  input  logic [4:0]           rs2_idx_i,
  input  logic [4:0]           rd_idx_i,
  input  logic                 rd_wen_i,
  input  logic [`CPU_XLEN-1:0] rd_wdata_i,
  output logic [`CPU_XLEN-1:0] rs1_data_o,
  output logic [`CPU_XLEN-1:0] rs2_data_o
);

  logic [`CPU_XLEN-1:0] regs_q [32];

  // x0 is never written
  always_ff @(posedge ACLK) begin
    if (rd_wen_i && (rd_idx_i != 5'd0)) begin
      regs_q[rd_idx_i] <= rd_wdata_i;
    end
  end

  // hardwired zero on x0
  assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs_q[rs2_idx_i];

endmodule

// File: soc_top.sv
`timescale 1ns/1ps

module soc_top (
  input  logic              ACLK,
  input  logic              ARESETn,
  input  logic              run_i,
  output logic              busy_o,
  output logic              err_o,
  input  logic              host_valid_i,
  input  cpu_pkg::mem_req_t host_req_i,
  output logic              host_done_o,
  output cpu_pkg::mem_rsp_t host_rsp_o
);
  import cpu_pkg::*;

  // core master sides
  logic     ifetch_valid;
  mem_req_t ifetch_req;
  logic     ifetch_done;
  mem_rsp_t ifetch_rsp;
  logic     data_valid;
  mem_req_t data_req;
  logic     data_done;
  mem_rsp_t data_rsp;

  // shared apb bus
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  cpu_core u_cpu_core (
    .ACLK,
    .ARESETn,
    .run_i,
    .busy_o,
    .err_o,
    .ifetch_valid_o (ifetch_valid),
    .ifetch_req_o   (ifetch_req),
    .ifetch_done_i  (ifetch_done),
    .ifetch_rsp_i   (ifetch_rsp),
    .data_valid_o   (data_valid),
    .data_req_o     (data_req),
    .data_done_i    (data_done),
    .data_rsp_i     (data_rsp)
  );

  bus_arbiter u_bus_arbiter (
    .ACLK,
    .ARESETn,
    .host_valid_i,
    .host_req_i,
    .host_done_o,
    .host_rsp_o,
    .data_valid_i  (data_valid),
    .data_req_i    (data_req),
    .data_done_o   (data_done),
    .data_rsp_o    (data_rsp),
    .fetch_valid_i (ifetch_valid),
    .fetch_req_i   (ifetch_req),
    .fetch_done_o  (ifetch_done),
    .fetch_rsp_o   (ifetch_rsp),
    .apb_o         (apb_req),
    .apb_i         (apb_rsp)
  );

  apb_ram u_apb_ram (
    .ACLK,
    .ARESETn,
    .apb_i (apb_req),
    .apb_o (apb_rsp)
  );

endmodule

// File: tb_soc.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_soc;
  import cpu_pkg::*;

  // rv32i opcodes
  localparam logic [6:0] opc_lui = 7'h37;
  localparam logic [6:0] opc_jal = 7'h6f;
  localparam logic [6:0] opc_jalr = 7'h67;
  localparam logic [6:0] opc_branch = 7'h63;
  localparam logic [6:0] opc_load = 7'h03;
  localparam logic [6:0] opc_store = 7'h23;
  localparam logic [6:0] opc_op_imm = 7'h13;
  localparam logic [6:0] opc_op = 7'h33;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam logic [31:0] bad_word = 32'h0000_007f;
  // all six tests need about 3000 cycles
  localparam int max_cycles = 20000;

  logic        ACLK;
  logic        ARESETn;
  logic        run;
  logic        busy;
  logic        err;
  logic        host_valid;
  mem_req_t    host_req;
  logic        host_done;
  mem_rsp_t    host_rsp;

  integer      seed;
  int          err_cnt;
  int          tests_pass;
  int          tests_fail;
  int          cycle_cnt = 0;
  logic [31:0] prog[$];
  logic [31:0] exp_q[$];
  logic [11:0] store_off;
  logic [31:0] seed_w[4];

  soc_top dut (
    .ACLK,
    .ARESETn,
    .run_i        (run),
    .busy_o       (busy),
    .err_o        (err),
    .host_valid_i (host_valid),
    .host_req_i   (host_req),
    .host_done_o  (host_done),
    .host_rsp_o   (host_rsp)
  );

  initial begin
    ACLK = 1'b0;
    forever #4 ACLK = ~ACLK;
  end

  always @(posedge ACLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // instruction encoders
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // always sw
  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic check_word(string name, mem_rsp_t got, mem_rsp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED host_rsp_o %s: got %h expected %h", name, got.rdata, exp.rdata);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(string name, int start_errs);
    if (err_cnt == start_errs) begin
      tests_pass++;
      $display("%s: pass", name);
    end else begin
      tests_fail++;
      $display("%s: fail with %0d bad checks", name, err_cnt - start_errs);
    end
  endtask

  // starts and ends just after a falling edge
  task automatic host_xfer(input logic is_write, input logic [31:0] req_addr,
                           input logic [31:0] req_data, output mem_rsp_t rsp);
    host_valid = 1'b1;
    host_req   = '{addr: req_addr, wdata: req_data, write: is_write};
    @(negedge ACLK);
    while (!host_done) @(negedge ACLK);
    rsp = host_rsp;
    // request stays up through the done edge
    @(negedge ACLK);
    host_valid = 1'b0;
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    mem_rsp_t unused;
    host_xfer(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input logic [31:0] addr, output mem_rsp_t rsp);
    host_xfer(1'b0, addr, 32'h0, rsp);
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // lui + addi with the upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] upper;
    upper = (val + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd));
    emit(i_type(val[11:0], rd, 3'b000, rd, opc_op_imm));
  endtask

  // result in x3 goes to the next store slot
  task automatic store_result(input logic [31:0] inst, input logic [31:0] exp);
    emit(inst);
    emit(s_type(store_off, 3, 0));
    exp_q.push_back(exp);
    store_off += 12'd4;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      host_write(32'(i * 4), prog[i]);
    end
  endtask

  task automatic start_core();
    run = 1'b1;
    @(negedge ACLK);
    run = 1'b0;
    check_flag("busy_o after run", busy, 1'b1);
  endtask

  task automatic run_program();
    load_program();
    start_core();
    while (busy) @(negedge ACLK);
  endtask

  task automatic host_path_test();
    int          start_errs;
    int          idx;
    logic [31:0] addr;
    logic [31:0] data;
    mem_rsp_t    rsp;
    start_errs = err_cnt;
    check_flag("busy_o after reset", busy, 1'b0);
    check_flag("err_o after reset", err, 1'b0);
    check_flag("host_done_o after reset", host_done, 1'b0);
    for (int i = 0; i < 8; i++) begin
      idx  = {$random(seed)} % `CPU_RAM_WORDS;
      addr = 32'(idx) << 2;
      data = $random(seed);
      host_write(addr, data);
      host_read(addr, rsp);
      check_word($sformatf("mem[%h]", addr), rsp, data);
    end
    // aliases above the depth hit the same word
    for (int i = 0; i < 4; i++) begin
      idx  = {$random(seed)} % `CPU_RAM_WORDS;
      addr = 32'(idx) << 2;
      data = $random(seed);
      host_write(addr + 32'((i + 1) * `CPU_RAM_WORDS * 4), data);
      host_read(addr, rsp);
      check_word($sformatf("mem[%h] via alias", addr), rsp, data);
      host_read(addr + 32'(`CPU_RAM_WORDS * 4 * 7), rsp);
      check_word($sformatf("mem[%h] read alias", addr), rsp, data);
    end
    finish_test("host path", start_errs);
  endtask

  task automatic alu_test();
    int          start_errs;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] c;
    logic [31:0] cx;
    mem_rsp_t    rsp;
    start_errs = err_cnt;
    a  = $random(seed);
    b  = $random(seed);
    c  = 12'($random(seed));
    cx = {{20{c[11]}}, c};
    prog.delete();
    exp_q.delete();
    store_off = 12'h400;
    load_const(1, a);
    load_const(2, b);
    store_result(r_type(7'h00, 2, 1, 3'b000, 3), a + b);
    store_result(r_type(7'h20, 2, 1, 3'b000, 3), a - b);
    store_result(r_type(7'h00, 2, 1, 3'b111, 3), a & b);
    store_result(r_type(7'h00, 2, 1, 3'b110, 3), a | b);
    store_result(r_type(7'h00, 2, 1, 3'b100, 3), a ^ b);
    store_result(r_type(7'h00, 2, 1, 3'b010, 3), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    store_result(r_type(7'h00, 1, 2, 3'b010, 3), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    store_result(i_type(c, 1, 3'b000, 3, opc_op_imm), a + cx);
    store_result(i_type(c, 1, 3'b111, 3, opc_op_imm), a & cx);
    store_result(i_type(c, 1, 3'b110, 3, opc_op_imm), a | cx);
    store_result(i_type(c, 1, 3'b100, 3, opc_op_imm), a ^ cx);
    store_result(i_type(c, 1, 3'b010, 3, opc_op_imm), ($signed(a) < $signed(cx)) ? 32'd1 : 32'd0);
    emit(ebreak_word);
    run_program();
    check_flag("err_o", err, 1'b0);
    foreach (exp_q[i]) begin
      host_read(32'h400 + 32'(i * 4), rsp);
      check_word($sformatf("alu result %0d", i), rsp, exp_q[i]);
    end
    finish_test("alu program", start_errs);
  endtask

  task automatic load_store_test();
    int          start_errs;
    logic [31:0] marker;
    mem_rsp_t    rsp;
    start_errs = err_cnt;
    marker = $random(seed) | 32'h1;
    for (int i = 0; i < 4; i++) begin
      seed_w[i] = $random(seed);
      host_write(32'h600 + 32'(i * 4), seed_w[i]);
    end
    host_write(32'h6a0, marker);
    prog.delete();
    for (int i = 0; i < 4; i++) begin
      emit(i_type(12'h600 + 12'(i * 4), 0, 3'b010, 5'(5 + i), opc_load));
    end
    for (int i = 0; i < 4; i++) begin
      emit(s_type(12'h680 + 12'(i * 4), 5'(5 + i), 0));
    end
    // load into x0 and store x0 over the marker
    emit(i_type(12'h600, 0, 3'b010, 0, opc_load));
    emit(s_type(12'h6a0, 0, 0));
    emit(ebreak_word);
    run_program();
    check_flag("err_o", err, 1'b0);
    for (int i = 0; i < 4; i++) begin
      host_read(32'h680 + 32'(i * 4), rsp);
      check_word($sformatf("copied word %0d", i), rsp, seed_w[i]);
    end
    host_read(32'h6a0, rsp);
    check_word("x0 store", rsp, 32'h0);
    finish_test("load/store", start_errs);
  endtask

  // sum loop at 12..20 and subroutine at 56
  task automatic build_loop_program(input int n);
    prog.delete();
    emit(i_type(12'(n), 0, 3'b000, 1, opc_op_imm));
    emit(i_type(12'd0, 0, 3'b000, 2, opc_op_imm));
    emit(i_type(12'd0, 0, 3'b000, 3, opc_op_imm));
    emit(i_type(12'd1, 3, 3'b000, 3, opc_op_imm));
    emit(r_type(7'h00, 3, 2, 3'b000, 2));
    emit(b_type(-13'd8, 1, 3, 3'b100));
    emit(b_type(13'd8, 0, 2, 3'b001));
    emit(i_type(12'd100, 2, 3'b000, 2, opc_op_imm));
    emit(s_type(12'h700, 2, 0));
    emit(j_type(21'd20, 5));
    emit(s_type(12'h704, 5, 0));
    emit(s_type(12'h708, 6, 0));
    emit(s_type(12'h70c, 7, 0));
    emit(ebreak_word);
    emit(i_type(12'd1, 2, 3'b000, 6, opc_op_imm));
    // odd offset that jalr clears in bit 0
    emit(i_type(12'd1, 5, 3'b000, 7, opc_jalr));
  endtask

  task automatic check_loop_results(input int n);
    logic [31:0] sum;
    mem_rsp_t    rsp;
    sum = 32'(n * (n + 1) / 2);
    host_read(32'h700, rsp);
    check_word("loop sum", rsp, sum);
    host_read(32'h704, rsp);
    check_word("jal link", rsp, 32'd40);
    host_read(32'h708, rsp);
    check_word("subroutine result", rsp, sum + 32'd1);
    host_read(32'h70c, rsp);
    check_word("jalr link", rsp, 32'd64);
  endtask

  task automatic control_flow_test();
    int start_errs;
    int n;
    start_errs = err_cnt;
    n = 5 + ({$random(seed)} % 16);
    build_loop_program(n);
    run_program();
    check_flag("err_o", err, 1'b0);
    check_loop_results(n);
    finish_test("control flow", start_errs);
  endtask

  task automatic termination_test();
    int          start_errs;
    logic [31:0] marker;
    mem_rsp_t    rsp;
    start_errs = err_cnt;
    marker = $random(seed) | 32'h1;
    host_write(32'h784, marker);
    prog.delete();
    emit(i_type(12'h066, 0, 3'b000, 1, opc_op_imm));
    emit(bad_word);
    emit(s_type(12'h784, 1, 0));
    emit(ebreak_word);
    run_program();
    check_flag("err_o on bad opcode", err, 1'b1);
    host_read(32'h784, rsp);
    check_word("store after bad opcode", rsp, marker);
    // the next run clears err_o
    prog.delete();
    emit(i_type(12'h055, 0, 3'b000, 1, opc_op_imm));
    emit(s_type(12'h780, 1, 0));
    emit(ebreak_word);
    run_program();
    check_flag("err_o on ebreak", err, 1'b0);
    host_read(32'h780, rsp);
    check_word("store before ebreak", rsp, 32'h55);
    finish_test("termination", start_errs);
  endtask

  task automatic arbitration_test();
    int          start_errs;
    int          n;
    int          reads;
    logic [31:0] addr;
    mem_rsp_t    rsp;
    start_errs = err_cnt;
    reads = 0;
    for (int i = 0; i < 4; i++) begin
      host_write(32'h700 + 32'(i * 4), $random(seed));
    end
    n = 5 + ({$random(seed)} % 16);
    build_loop_program(n);
    load_program();
    start_core();
    while (busy) begin
      addr = 32'h600 + 32'((reads % 4) * 4);
      host_read(addr, rsp);
      check_word($sformatf("mem[%h] during run", addr), rsp, seed_w[reads % 4]);
      reads++;
      // one idle cycle so the core can win the bus
      @(negedge ACLK);
    end
    check_flag("err_o", err, 1'b0);
    check_loop_results(n);
    finish_test("arbitration", start_errs);
  endtask

  initial begin
    ARESETn    = 1'b0;
    run        = 1'b0;
    host_valid = 1'b0;
    host_req   = '0;
    seed       = 32'h9ee0;
    err_cnt    = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (3) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;
    host_path_test();
    alu_test();
    load_store_test();
    control_flow_test();
    termination_test();
    arbitration_test();
    $display("summary: %0d tests passed, %0d tests failed, %0d bad checks",
             tests_pass, tests_fail, err_cnt);
    if (tests_fail == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
